// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= wiscCore_tb
FILELIST ?= wiscCore.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= test passed

SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== src/alu.sv ====
// ALU with add, logic, rotate, shift, bit reverse and compare flags
`timescale 1ns/1ps
`default_nettype none

`include "wisc_macros.svh"

module alu import wisc_pkg::*; (
	input word_t a,
	input word_t b,
	ctrlIf.datapath ctrl,
	output word_t result,
	output logic zero,
	output logic neg,
	output logic carry
);

	logic [3:0] shamt;
	logic [`WORD_W:0] sum;
	logic [2*`WORD_W-1:0] rolWide, rorWide;
	word_t diff;
	word_t rev;

	assign shamt = b[3:0];
	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = b - a;

	// Rotating a doubled word leaves the wrapped bits in one half
	assign rolWide = {a, a} << shamt;
	assign rorWide = {a, a} >> shamt;

	always_comb begin
		for (int i = 0; i < `WORD_W; i++) begin
			rev[i] = a[`WORD_W-1-i];
		end
	end

	always_comb begin
		case (ctrl.aluOp)
			ALU_ROL: result = rolWide[2*`WORD_W-1:`WORD_W];
			ALU_SLL: result = a << shamt;
			ALU_ROR: result = rorWide[`WORD_W-1:0];
			ALU_SRL: result = a >> shamt;
			ALU_ADD: result = sum[`WORD_W-1:0];
			ALU_SUB: result = diff;
			ALU_XOR: result = a ^ b;
			// andi masks with the immediate as given
			ALU_ANDN: result = ctrl.aluSrc ? (a & b) : (a & ~b);
			ALU_OR: result = (a << 8) | b;
			ALU_BTR: result = rev;
			default: result = b;
		endcase
	end

	// For sub, neg is the true signed b < a, immune to overflow
	assign zero = (result == '0);
	assign neg = (ctrl.aluOp == ALU_SUB) ? ($signed(b) < $signed(a)) : result[`WORD_W-1];
	assign carry = sum[`WORD_W];

endmodule

`default_nettype wire

// ==== src/control.sv ====
// Opcode decoder producing the control levels of the current instruction
`timescale 1ns/1ps
`default_nettype none

module control import wisc_pkg::*; (
	input word_t instr,
	ctrlIf.decoder ctrl
);

	opcode_e op;

	assign op = opcode_e'(instr[15:11]);

	always_comb begin
		// Everything off, which is also nop, siic and rti
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.aluSrc = 1'b0;
		ctrl.aluOp = ALU_ADD;
		ctrl.immSel = IMM_ZEXT5;
		ctrl.setSel = SET_ALU;
		ctrl.regDst = REG_DST_RD_I;
		ctrl.branchCtl = 1'b0;
		ctrl.jumpCtl = 1'b0;
		ctrl.jrCtl = 1'b0;
		ctrl.linkCtl = 1'b0;
		ctrl.stu = 1'b0;
		ctrl.halt = 1'b0;

		case (op)
			OP_HALT: ctrl.halt = 1'b1;
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluOp_e'({2'b01, op[1:0]});
				// addi and subi sign extend, the logic ops zero extend
				ctrl.immSel = op[1] ? IMM_ZEXT5 : IMM_SEXT5;
			end
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = aluOp_e'({2'b00, op[1:0]});
			end
			OP_SHIFT, OP_ALU: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = REG_DST_RD_R;
				ctrl.aluOp = aluOp_e'({1'b0, op[0], instr[1:0]});
			end
			OP_BTR: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = REG_DST_RD_R;
				ctrl.aluOp = ALU_BTR;
			end
			OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = REG_DST_RD_R;
				ctrl.aluOp = (op == OP_SCO) ? ALU_ADD : ALU_SUB;
				ctrl.setSel = setSel_e'({1'b0, op[1:0]} + 3'd1);
			end
			OP_LBI, OP_SLBI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.regDst = REG_DST_RS;
				ctrl.aluOp = (op == OP_LBI) ? ALU_PASSB : ALU_OR;
				ctrl.immSel = (op == OP_LBI) ? IMM_SEXT8 : IMM_ZEXT8;
			end
			OP_ST, OP_LD, OP_STU: begin
				ctrl.aluSrc = 1'b1;
				ctrl.immSel = IMM_SEXT5;
				ctrl.memWrite = (op != OP_LD);
				ctrl.memRead = (op == OP_LD);
				ctrl.regWrite = (op != OP_ST);
				ctrl.stu = (op == OP_STU);
				ctrl.setSel = (op == OP_LD) ? SET_MEM : SET_ALU;
				ctrl.regDst = (op == OP_STU) ? REG_DST_RS : REG_DST_RD_I;
			end
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
				ctrl.branchCtl = 1'b1;
				ctrl.immSel = IMM_SEXT8;
			end
			OP_J, OP_JR, OP_JAL, OP_JALR: begin
				ctrl.jumpCtl = 1'b1;
				ctrl.jrCtl = op[0];
				ctrl.immSel = op[0] ? IMM_SEXT8 : IMM_SEXT11;
				ctrl.linkCtl = op[1];
				ctrl.regWrite = op[1];
				ctrl.regDst = REG_DST_R7;
				ctrl.setSel = SET_LINK;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/ctrlIf.sv ====
// Decoded control levels shared by the decoder and the datapath
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import wisc_pkg::*; ();

	logic regWrite, memWrite, memRead;
	logic aluSrc;
	aluOp_e aluOp;
	immSel_e immSel;
	setSel_e setSel;
	regDst_e regDst;
	logic branchCtl, jumpCtl, jrCtl, linkCtl, stu;
	logic halt;

	modport decoder (
		output regWrite, memWrite, memRead, aluSrc, aluOp, immSel, setSel, regDst,
		output branchCtl, jumpCtl, jrCtl, linkCtl, stu, halt
	);

	modport datapath (
		input regWrite, memWrite, memRead, aluSrc, aluOp, immSel, setSel, regDst,
		input branchCtl, jumpCtl, jrCtl, linkCtl, stu, halt
	);

endinterface

`default_nettype wire

// ==== src/dataMem.sv ====
// Word-addressed data memory with load port and combinational read
`timescale 1ns/1ps
`default_nettype none

`include "wisc_macros.svh"

module dataMem import wisc_pkg::*; (
	input logic clk,
	input logic rstN,
	input logic dmemWe,
	input logic [$clog2(`DMEM_DEPTH)-1:0] dmemAddr,
	input word_t dmemData,
	input word_t addr,
	input word_t wData,
	ctrlIf.datapath ctrl,
	input logic halted,
	output word_t rData
);

	localparam int AW = $clog2(`DMEM_DEPTH);

	word_t mem [`DMEM_DEPTH];
	logic [AW-1:0] idx;

	// Byte address to word index
	assign idx = addr[AW:1];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			if (dmemWe)
				mem[dmemAddr] <= dmemData;
		end else if (ctrl.memWrite && !halted) begin
			mem[idx] <= wData;
		end
	end

	assign rData = ctrl.memRead ? mem[idx] : '0;

endmodule

`default_nettype wire

// ==== src/fetch.sv ====
// PC register, instruction memory, next-PC selection and halt latch
`timescale 1ns/1ps
`default_nettype none

`include "wisc_macros.svh"

module fetch import wisc_pkg::*; (
	input logic clk,
	input logic rstN,
	input logic imemWe,
	input logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
	input word_t imemData,
	input word_t regA,
	input word_t imm,
	ctrlIf.datapath ctrl,
	input logic zero,
	input logic neg,
	output word_t instr,
	output word_t pc,
	output word_t pcPlus2,
	output logic halted
);

	localparam int AW = $clog2(`IMEM_DEPTH);
	localparam word_t HALT_WORD = {OP_HALT, {(`WORD_W-5){1'b0}}};

	word_t imem [`IMEM_DEPTH];
	word_t nextPc;
	logic condMet;

	always_ff @(posedge clk) begin
		if (!rstN && imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// Decoder sees halt in reset and once halted, so nothing writes
	assign instr = (halted || !rstN) ? HALT_WORD : imem[pc[AW:1]];
	assign pcPlus2 = pc + word_t'(2);

	// beqz, bnez, bltz, bgez by opcode low bits
	always_comb begin
		case (instr[12:11])
			2'b00: condMet = zero;
			2'b01: condMet = !zero;
			2'b10: condMet = neg;
			default: condMet = !neg;
		endcase
	end

	always_comb begin
		if (ctrl.jrCtl)
			nextPc = regA + imm;
		else if (ctrl.jumpCtl || (ctrl.branchCtl && condMet))
			nextPc = pcPlus2 + imm;
		else
			nextPc = pcPlus2;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			pc <= nextPc;
			halted <= ctrl.halt;
		end
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
// Eight-entry register file, two combinational reads and one clocked write
`timescale 1ns/1ps
`default_nettype none

`include "wisc_macros.svh"

module regFile import wisc_pkg::*; (
	input logic clk,
	input logic rstN,
	input regIdx_t rdA,
	input regIdx_t rdB,
	output word_t dataA,
	output word_t dataB,
	input regIdx_t wrReg,
	input word_t wrData,
	ctrlIf.datapath ctrl
);

	word_t regs [`NUM_REGS];

	// A halted core keeps decoding halt, so regWrite stays low then
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite) begin
			regs[wrReg] <= wrData;
		end
	end

	// Reads see the old value on a write edge
	assign dataA = regs[rdA];
	assign dataB = regs[rdB];

endmodule

`default_nettype wire

// ==== src/wiscCore.sv ====
// Single-cycle WISC core top level with immediate and writeback muxes
`timescale 1ns/1ps
`default_nettype none

`include "wisc_macros.svh"

module wiscCore import wisc_pkg::*; (
	input logic clk,
	input logic rstN,
	input logic imemWe,
	input logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
	input word_t imemData,
	input logic dmemWe,
	input logic [$clog2(`DMEM_DEPTH)-1:0] dmemAddr,
	input word_t dmemData,
	output word_t pc,
	output logic halted,
	output logic wbEn,
	output regIdx_t wbReg,
	output word_t wbData,
	output logic memWe,
	output word_t memAddr,
	output word_t memWData
);

	ctrlIf ctrl();

	word_t instr, pcPlus2, regA, regB, immExt, aluB, aluResult, memData, wrData;
	regIdx_t wrReg;
	logic zero, neg, carry;

	control control_inst (.instr(instr), .ctrl(ctrl.decoder));

	fetch fetch_inst (
		.clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.regA(regA), .imm(immExt), .ctrl(ctrl.datapath), .zero(zero), .neg(neg),
		.instr(instr), .pc(pc), .pcPlus2(pcPlus2), .halted(halted)
	);

	regFile regFile_inst (
		.clk(clk), .rstN(rstN), .rdA(instr[10:8]), .rdB(instr[7:5]),
		.dataA(regA), .dataB(regB), .wrReg(wrReg), .wrData(wrData), .ctrl(ctrl.datapath)
	);

	always_comb begin
		case (ctrl.immSel)
			IMM_SEXT5: immExt = {{(`WORD_W-5){instr[4]}}, instr[4:0]};
			IMM_ZEXT8: immExt = {{(`WORD_W-8){1'b0}}, instr[7:0]};
			IMM_SEXT8: immExt = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
			IMM_SEXT11: immExt = {{(`WORD_W-11){instr[10]}}, instr[10:0]};
			default: immExt = {{(`WORD_W-5){1'b0}}, instr[4:0]};
		endcase
	end

	// Branches test rs against zero
	assign aluB = ctrl.aluSrc ? immExt : (ctrl.branchCtl ? '0 : regB);

	alu alu_inst (
		.a(regA), .b(aluB), .ctrl(ctrl.datapath), .result(aluResult),
		.zero(zero), .neg(neg), .carry(carry)
	);

	dataMem dataMem_inst (
		.clk(clk), .rstN(rstN), .dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemData(dmemData),
		.addr(aluResult), .wData(regB), .ctrl(ctrl.datapath), .halted(halted), .rData(memData)
	);

	always_comb begin
		if (ctrl.stu)
			wrReg = instr[10:8];
		else if (ctrl.linkCtl)
			wrReg = regIdx_t'(`NUM_REGS - 1);
		else if (ctrl.regDst == REG_DST_RD_R)
			wrReg = instr[4:2];
		else if (ctrl.regDst == REG_DST_RS)
			wrReg = instr[10:8];
		else
			wrReg = instr[7:5];
	end

	// slt and sle use neg as rt < rs from b - a
	always_comb begin
		case (ctrl.setSel)
			SET_SEQ: wrData = word_t'(zero);
			SET_SLT: wrData = word_t'(!neg && !zero);
			SET_SLE: wrData = word_t'(!neg);
			SET_SCO: wrData = word_t'(carry);
			SET_MEM: wrData = memData;
			SET_LINK: wrData = pcPlus2;
			default: wrData = aluResult;
		endcase
	end

	assign wbEn = ctrl.regWrite;
	assign wbReg = wrReg;
	assign wbData = wrData;
	assign memWe = ctrl.memWrite;
	assign memAddr = aluResult;
	assign memWData = regB;

endmodule

`default_nettype wire

// ==== src/wisc_macros.svh ====
// Word width, register count and memory depths for the WISC core
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

// Data and instruction word
`define WORD_W 16

// General registers r0 to r7
`define NUM_REGS 8

// Memory depths in words
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

`endif

// ==== src/wisc_pkg.sv ====
// Word and register types, opcode, ALU and select enums for the WISC core
`default_nettype none

`include "wisc_macros.svh"

package wisc_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;

	// Major opcodes, instr[15:11]
	typedef enum logic [4:0] {
		OP_HALT = 5'b00000, OP_NOP, OP_SIIC, OP_RTI,
		OP_J = 5'b00100, OP_JR, OP_JAL, OP_JALR,
		OP_ADDI = 5'b01000, OP_SUBI, OP_XORI, OP_ANDI,
		OP_BEQZ = 5'b01100, OP_BNEZ, OP_BLTZ, OP_BGEZ,
		OP_ST = 5'b10000, OP_LD, OP_SLBI, OP_STU,
		OP_ROLI = 5'b10100, OP_SLLI, OP_RORI, OP_SRLI,
		OP_LBI = 5'b11000, OP_BTR, OP_SHIFT, OP_ALU,
		OP_SEQ = 5'b11100, OP_SLT, OP_SLE, OP_SCO
	} opcode_e;

	// Low two bits follow the function field of the R-format groups
	typedef enum logic [3:0] {
		ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN,
		ALU_OR, ALU_BTR, ALU_PASSB
	} aluOp_e;

	typedef enum logic [2:0] {
		IMM_ZEXT5, IMM_SEXT5, IMM_ZEXT8, IMM_SEXT8, IMM_SEXT11
	} immSel_e;

	// Writeback source
	typedef enum logic [2:0] {
		SET_ALU, SET_SEQ, SET_SLT, SET_SLE, SET_SCO, SET_MEM, SET_LINK
	} setSel_e;

	// Destination register field
	typedef enum logic [1:0] {
		REG_DST_RD_R, REG_DST_RD_I, REG_DST_RS, REG_DST_R7
	} regDst_e;

endpackage

`default_nettype wire

// ==== testbench/tbClock.sv ====
// Free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== testbench/wiscCore_asserts.sv ====
// Bound assertions on halt latching, writes while halted and PC progress
`timescale 1ns/1ps
`default_nettype none

module wiscCore_asserts import wisc_pkg::*; (
	input logic clk,
	input logic rstN,
	input word_t pc,
	input logic halted,
	input logic wbEn,
	input logic memWe
);

	// Halt holds until the next reset
	haltHeld: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
		else $error("halted fell while out of reset");

	noWriteHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> (!wbEn && !memWe))
		else $error("register or memory write enabled while halted");

	// Every retired instruction moves the PC
	pcMoves: assert property (@(posedge clk) disable iff (!rstN)
		!halted |=> (pc != $past(pc)))
		else $error("pc did not change on a running cycle");

endmodule

`default_nettype wire

// ==== testbench/wiscCore_tb.sv ====
// Directed program tests for the WISC core, trace checks, watchdog and report
`timescale 1ns/1ps
`default_nettype none

`include "wisc_macros.svh"

module wiscCore_tb import wisc_pkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int CYCLE_NS = 40;
	localparam int IAW = $clog2(`IMEM_DEPTH);
	localparam int DAW = $clog2(`DMEM_DEPTH);

	logic clk, rstN, imemWe, dmemWe, halted, wbEn, memWe;
	logic [IAW-1:0] imemAddr;
	logic [DAW-1:0] dmemAddr;
	word_t imemData, dmemData, pc, wbData, memAddr, memWData;
	regIdx_t wbReg;

	int errors = 0;
	int seed = 32'h314b_dd7e;
	word_t prog [64];
	int progLen;
	logic preValid;
	word_t preAddr, preData;
	regIdx_t wbRegQ [$];
	word_t wbDataQ [$];
	word_t memAddrQ [$];
	word_t memDataQ [$];
	word_t pcQ [$];

	tbClock #(.PERIOD_NS(CYCLE_NS)) clkGen (.clk(clk));

	wiscCore wiscCore_inst (.*);

	bind wiscCore wiscCore_asserts wiscCore_asserts_inst (
		.clk(clk), .rstN(rstN), .pc(pc), .halted(halted), .wbEn(wbEn), .memWe(memWe)
	);

	// Instruction encoders
	function automatic word_t enc1(opcode_e op, regIdx_t rs, regIdx_t rd, logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic word_t encR(opcode_e op, regIdx_t rs, regIdx_t rt, regIdx_t rd,
			logic [1:0] fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic word_t enc2(opcode_e op, regIdx_t rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic word_t encJ(opcode_e op, logic [10:0] disp);
		return {op, disp};
	endfunction

	// Kind 0 rol, 1 sll, 2 ror, 3 srl
	function automatic word_t shiftModel(int kind, word_t v, int n);
		case (kind)
			0: return (v << n) | (v >> (16 - n));
			1: return v << n;
			2: return (v >> n) | (v << (16 - n));
			default: return v >> n;
		endcase
	endfunction

	function automatic word_t reverseBits(word_t v);
		word_t r;
		for (int i = 0; i < 16; i++) begin
			r[15-i] = v[i];
		end
		return r;
	endfunction

	task automatic checkWord(string name, word_t got, word_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkReg(string name, regIdx_t got, regIdx_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic expectWb(regIdx_t r, word_t d);
		if (wbRegQ.size() == 0) begin
			errors++;
			$display("Missing register write, expected r%0d", r);
		end else begin
			checkReg("wbReg", wbRegQ.pop_front(), r);
			checkWord("wbData", wbDataQ.pop_front(), d);
		end
	endtask

	task automatic expectMem(word_t a, word_t d);
		if (memAddrQ.size() == 0) begin
			errors++;
			$display("Missing memory write, expected address %h", a);
		end else begin
			checkWord("memAddr", memAddrQ.pop_front(), a);
			checkWord("memWData", memDataQ.pop_front(), d);
		end
	endtask

	task automatic expectDrained();
		if (wbRegQ.size() != 0 || memAddrQ.size() != 0) begin
			errors++;
			$display("Unexpected extra register or memory writes in the trace");
		end
	endtask

	task automatic startTest();
		progLen = 0;
		preValid = 1'b0;
		foreach (prog[i]) begin
			prog[i] = '0;
		end
		wbRegQ.delete();
		wbDataQ.delete();
		memAddrQ.delete();
		memDataQ.delete();
		pcQ.delete();
	endtask

	task automatic emit(word_t w);
		prog[progLen] = w;
		progLen++;
	endtask

	task automatic place(int byteAddr, word_t w);
		prog[byteAddr / 2] = w;
		if (byteAddr / 2 >= progLen)
			progLen = byteAddr / 2 + 1;
	endtask

	// lbi then slbi builds any 16-bit value
	task automatic loadConst(regIdx_t r, word_t v);
		emit(enc2(OP_LBI, r, v[15:8]));
		emit(enc2(OP_SLBI, r, v[7:0]));
	endtask

	task automatic expectConst(regIdx_t r, word_t v);
		expectWb(r, {{8{v[15]}}, v[15:8]});
		expectWb(r, v);
	endtask

	// Close with halt, load during reset and trace until halted
	task automatic runProgram();
		int loadCycles;
		emit({OP_HALT, 11'b0});
		loadCycles = (progLen > 4) ? progLen : 4;
		@(posedge clk);
		#2;
		rstN = 1'b0;
		for (int i = 0; i < loadCycles; i++) begin
			imemWe = (i < progLen);
			imemAddr = IAW'(i);
			imemData = prog[i];
			dmemWe = preValid && (i == 0);
			dmemAddr = preAddr[DAW:1];
			dmemData = preData;
			@(posedge clk);
			#2;
		end
		imemWe = 1'b0;
		dmemWe = 1'b0;
		rstN = 1'b1;
		forever begin
			@(negedge clk);
			if (halted)
				break;
			pcQ.push_back(pc);
			if (wbEn) begin
				wbRegQ.push_back(wbReg);
				wbDataQ.push_back(wbData);
			end
			if (memWe) begin
				memAddrQ.push_back(memAddr);
				memDataQ.push_back(memWData);
			end
		end
	endtask

	task automatic aluTest();
		word_t a, b, imm;
		logic [4:0] imm5;
		a = $random(seed);
		b = $random(seed);
		imm5 = $random(seed);
		imm = {{11{imm5[4]}}, imm5};
		startTest();
		loadConst(1, a);
		loadConst(2, b);
		for (int k = 0; k < 4; k++) begin
			emit(enc1(opcode_e'(OP_ADDI + k), 1, 3, imm5));
		end
		for (int k = 0; k < 4; k++) begin
			emit(encR(OP_ALU, 1, 2, 4, 2'(k)));
		end
		runProgram();
		expectConst(1, a);
		expectConst(2, b);
		expectWb(3, a + imm);
		expectWb(3, imm - a);
		expectWb(3, a ^ {11'b0, imm5});
		expectWb(3, a & {11'b0, imm5});
		expectWb(4, a + b);
		expectWb(4, b - a);
		expectWb(4, a ^ b);
		expectWb(4, a & ~b);
		expectDrained();
	endtask

	task automatic shiftTest();
		word_t a;
		logic [3:0] sh;
		a = $random(seed);
		sh = $random(seed);
		startTest();
		loadConst(1, a);
		emit(enc2(OP_LBI, 2, {4'b0, sh}));
		for (int k = 0; k < 4; k++) begin
			emit(enc1(opcode_e'(OP_ROLI + k), 1, 3, {1'b0, sh}));
		end
		for (int k = 0; k < 4; k++) begin
			emit(encR(OP_SHIFT, 1, 2, 4, 2'(k)));
		end
		emit(encR(OP_BTR, 1, 0, 5, 2'b00));
		runProgram();
		expectConst(1, a);
		expectWb(2, {12'b0, sh});
		for (int k = 0; k < 4; k++) begin
			expectWb(3, shiftModel(k, a, sh));
		end
		for (int k = 0; k < 4; k++) begin
			expectWb(4, shiftModel(k, a, sh));
		end
		expectWb(5, reverseBits(a));
		expectDrained();
	endtask

	// Equal, lower and higher pairs with no overflow on x + 5
	task automatic setTest();
		word_t x;
		word_t lhs [3];
		word_t rhs [3];
		logic [16:0] sum;
		x = $random(seed) & 16'hbff0;
		lhs = '{x, x, x + 16'd5};
		rhs = '{x, x + 16'd5, x};
		startTest();
		for (int p = 0; p < 3; p++) begin
			loadConst(1, lhs[p]);
			loadConst(2, rhs[p]);
			for (int k = 0; k < 4; k++) begin
				emit(encR(opcode_e'(OP_SEQ + k), 1, 2, 3, 2'b00));
			end
		end
		runProgram();
		for (int p = 0; p < 3; p++) begin
			sum = {1'b0, lhs[p]} + {1'b0, rhs[p]};
			expectConst(1, lhs[p]);
			expectConst(2, rhs[p]);
			expectWb(3, word_t'(lhs[p] == rhs[p]));
			expectWb(3, word_t'($signed(lhs[p]) < $signed(rhs[p])));
			expectWb(3, word_t'($signed(lhs[p]) <= $signed(rhs[p])));
			expectWb(3, word_t'(sum[16]));
		end
		expectDrained();
	endtask

	task automatic memTest();
		word_t d, p;
		d = $random(seed);
		p = $random(seed);
		startTest();
		preValid = 1'b1;
		preAddr = 16'h000c;
		preData = p;
		emit(enc2(OP_LBI, 1, 8'h40));
		loadConst(2, d);
		emit(enc1(OP_ST, 1, 2, 5'd4));
		emit(enc1(OP_LD, 1, 3, 5'd4));
		emit(enc1(OP_STU, 1, 2, 5'h1e));
		emit(enc1(OP_LD, 0, 4, 5'd12));
		runProgram();
		expectWb(1, 16'h0040);
		expectConst(2, d);
		expectMem(16'h0044, d);
		expectWb(3, d);
		expectMem(16'h003e, d);
		expectWb(1, 16'h003e);
		expectWb(4, p);
		expectDrained();
	endtask

	task automatic branchTest();
		word_t pcs [16] = '{0, 2, 6, 8, 10, 14, 16, 18, 22, 26, 28, 34, 38, 40, 48, 54};
		startTest();
		place(0, enc2(OP_LBI, 1, 8'h00));
		place(2, enc2(OP_BEQZ, 1, 8'd2));
		place(6, enc2(OP_BNEZ, 1, 8'd2));
		place(8, enc2(OP_LBI, 2, 8'hff));
		place(10, enc2(OP_BLTZ, 2, 8'd2));
		place(14, enc2(OP_BGEZ, 2, 8'd2));
		place(16, enc2(OP_BLTZ, 1, 8'd2));
		place(18, enc2(OP_BGEZ, 1, 8'd2));
		place(22, enc2(OP_BNEZ, 2, 8'd2));
		place(26, enc2(OP_BEQZ, 2, 8'd2));
		place(28, encJ(OP_J, 11'd4));
		place(34, encJ(OP_JAL, 11'd2));
		place(38, enc2(OP_LBI, 3, 8'd46));
		place(40, enc2(OP_JR, 3, 8'd2));
		place(48, enc2(OP_JALR, 3, 8'd8));
		place(54, '0);
		runProgram();
		foreach (pcs[i]) begin
			if (pcQ.size() == 0) begin
				errors++;
				$display("Trace ended early, expected pc %h", pcs[i]);
			end else begin
				checkWord("pc", pcQ.pop_front(), pcs[i]);
			end
		end
		expectWb(1, 16'h0000);
		expectWb(2, 16'hffff);
		expectWb(7, 16'd36);
		expectWb(3, 16'd46);
		expectWb(7, 16'd50);
		expectDrained();
	endtask

	task automatic haltTest();
		startTest();
		emit({OP_NOP, 11'b0});
		emit({OP_SIIC, 11'b0});
		emit({OP_RTI, 11'b0});
		emit({OP_HALT, 11'b0});
		runProgram();
		expectDrained();
		checkWord("pc", pcQ[$], 16'd6);
		// The halt edge still advances the PC once
		repeat (3) begin
			@(negedge clk);
			checkWord("pc", pc, 16'd8);
			if (!halted || wbEn || memWe) begin
				errors++;
				$display("Halted core dropped halted or enabled a write");
			end
		end
	endtask

	initial begin
		rstN = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		dmemWe = 1'b0;
		dmemAddr = '0;
		dmemData = '0;
		preAddr = '0;
		preData = '0;
		aluTest();
		shiftTest();
		setTest();
		memTest();
		branchTest();
		haltTest();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		#(200 * NUM_TESTS * CYCLE_NS);
		$display("Watchdog expired before all tests completed");
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== wiscCore.f ====
+incdir+src
src/wisc_pkg.sv
src/ctrlIf.sv
src/control.sv
src/regFile.sv
src/alu.sv
src/fetch.sv
src/dataMem.sv
src/wiscCore.sv
testbench/tbClock.sv
testbench/wiscCore_asserts.sv
testbench/wiscCore_tb.sv
